/* compile.f */
verilog/trap_pkg.sv
verilog/ctrl_csr_if.sv
verilog/trap_csr.sv
verilog/trap_ctrl.sv
verilog/fetch_pc.sv
verilog/trap_unit.sv
test/trap_unit_chk.sv
test/trap_unit_tb.sv

/* test/trap_unit_chk.sv */
module trap_unit_chk
    import trap_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input logic               clk,
    input logic               arst_n_i,
    input logic [4:0]         pause_i,    // if, id, dispatch, ex, mem
    input logic [31:0]        mem_pc_i,
    input logic [5:0]         mem_is_exception_i,
    input logic [5:0][6:0]    mem_exception_cause_i,
    input logic               mem_is_ertn_i,
    input logic               mem_is_idle_i,
    input logic               continue_idle_i,
    input logic [7:0]         hw_int_i,
    input logic               wb_csr_we_i,
    input logic [13:0]        wb_csr_addr_i,
    input logic [31:0]        wb_csr_wdata_i,
    input logic [13:0]        csr_raddr_i,
    input logic [STALL_W-1:0] pause_o,
    input logic               flush_o,
    input logic [31:0]        new_pc_o,
    input logic               is_interrupt_o,
    input logic               send_inst1_en_o,
    input logic [31:0]        pc_o,
    input logic [31:0]        csr_rdata_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned err_cnt = 0;

    // shadow of the architectural csr state
    logic [31:0]        sh_era;
    logic [31:0]        sh_eentry;
    logic [31:0]        sh_pc;
    logic [8:0]         sh_crmd;
    logic [2:0]         sh_prmd;
    logic [11:0]        sh_lie;
    logic [11:0]        sh_is;
    logic [5:0]         sh_ecode;

    logic [31:0]        f_era;
    logic [31:0]        f_eentry;
    logic [11:0]        f_lie;
    logic [11:0]        f_is;
    logic               f_ie;
    logic               f_pie;
    logic               exp_exc;
    logic               exp_ertn;
    logic               exp_int;
    logic [6:0]         exp_cause;
    logic [31:0]        exp_new_pc;
    logic [STALL_W-1:0] exp_stall;
    logic [31:0]        exp_rdata;

    task automatic note_error(input string name, input logic [31:0] got, input logic [31:0] exp);
        err_cnt++;
        $error("Error %s got %h expected %h", name, got, exp);
    endtask

    always_comb begin
        f_era    = sh_era;
        f_eentry = sh_eentry;
        f_lie    = sh_lie;
        f_is     = sh_is;
        f_ie     = sh_crmd[2];
        f_pie    = sh_prmd[2];
        if (wb_csr_we_i) begin
            case (wb_csr_addr_i)
                ERA:    f_era    = wb_csr_wdata_i;
                EENTRY: f_eentry = wb_csr_wdata_i;
                ECFG:   f_lie    = {wb_csr_wdata_i[12:11], wb_csr_wdata_i[9:0]};
                ESTAT:  f_is     = {wb_csr_wdata_i[12:11], sh_is[9:2], wb_csr_wdata_i[1:0]};
                CRMD:   f_ie     = wb_csr_wdata_i[2];
                PRMD:   f_pie    = wb_csr_wdata_i[2];
                default: ;
            endcase
        end
        exp_cause = 7'h7f;
        for (int k = 0; k < 6; k++) begin
            if (mem_is_exception_i[k]) begin
                exp_cause = mem_exception_cause_i[k];
            end
        end
        exp_exc    = (mem_pc_i != 32'hfc) && (mem_is_exception_i != '0);
        exp_ertn   = (mem_pc_i != 32'hfc) && mem_is_ertn_i && !exp_exc;
        exp_new_pc = exp_ertn ? f_era : f_eentry;
        exp_int    = f_ie && ((f_lie & f_is) != '0);
        exp_stall  = pause_i[4] ? 7'b000_0001 :
                     pause_i[3] ? 7'b000_1111 :
                     pause_i[2] ? 7'b001_1111 :
                     pause_i[1] ? 7'b011_1111 :
                     (pause_i[0] || (mem_is_idle_i && !exp_int && !continue_idle_i)) ?
                         7'b111_1111 : 7'b000_0000;
        case (csr_raddr_i)
            CRMD:    exp_rdata = {23'b0, sh_crmd};
            PRMD:    exp_rdata = {29'b0, sh_prmd};
            ECFG:    exp_rdata = {19'b0, sh_lie[11:10], 1'b0, sh_lie[9:0]};
            ESTAT:   exp_rdata = {10'b0, sh_ecode, 3'b0, sh_is[11:10], 1'b0, sh_is[9:0]};
            ERA:     exp_rdata = sh_era;
            EENTRY:  exp_rdata = sh_eentry;
            default: exp_rdata = 32'h0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sh_era    <= '0;
            sh_eentry <= '0;
            sh_crmd   <= '0;
            sh_prmd   <= '0;
            sh_lie    <= '0;
            sh_is     <= '0;
            sh_ecode  <= '0;
            sh_pc     <= RESET_PC;
        end
        else begin
            sh_era    <= f_era;
            sh_eentry <= f_eentry;
            sh_lie    <= f_lie;
            sh_is     <= {f_is[11:10], hw_int_i, f_is[1:0]};
            if (wb_csr_we_i && wb_csr_addr_i == CRMD) begin
                sh_crmd <= wb_csr_wdata_i[8:0];
            end
            if (wb_csr_we_i && wb_csr_addr_i == PRMD) begin
                sh_prmd <= wb_csr_wdata_i[2:0];
            end
            if (exp_exc) begin
                sh_era     <= mem_pc_i;
                sh_ecode   <= exp_cause[5:0];
                sh_prmd[2] <= f_ie;
                sh_crmd[2] <= 1'b0;
            end
            else if (exp_ertn) begin
                sh_crmd[2] <= f_pie;
            end
            if (exp_exc || exp_ertn) begin
                sh_pc <= exp_new_pc;
            end
            else if (!exp_stall[STALL_PC]) begin
                sh_pc <= sh_pc + 32'd8; // two-instruction group
            end
        end
    end

    a_flush: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_o == (exp_exc || exp_ertn))
        else note_error("flush_o", $sampled(flush_o), $sampled(exp_exc || exp_ertn));
    a_new_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        flush_o |-> new_pc_o == exp_new_pc)
        else note_error("new_pc_o", $sampled(new_pc_o), $sampled(exp_new_pc));
    a_interrupt: assert property (@(posedge clk) disable iff (!arst_n_i)
        is_interrupt_o == exp_int)
        else note_error("is_interrupt_o", $sampled(is_interrupt_o), $sampled(exp_int));
    a_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
        pause_o == exp_stall)
        else note_error("pause_o", $sampled(pause_o), $sampled(exp_stall));
    a_send_inst1: assert property (@(posedge clk) disable iff (!arst_n_i)
        send_inst1_en_o == !exp_stall[STALL_IBUF])
        else note_error("send_inst1_en_o", $sampled(send_inst1_en_o),
                        $sampled(!exp_stall[STALL_IBUF]));
    a_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        pc_o == sh_pc)
        else note_error("pc_o", $sampled(pc_o), $sampled(sh_pc));
    a_rdata: assert property (@(posedge clk) disable iff (!arst_n_i)
        csr_rdata_o == exp_rdata)
        else note_error("csr_rdata_o", $sampled(csr_rdata_o), $sampled(exp_rdata));

endmodule

bind trap_unit trap_unit_chk #(
    .RESET_PC (RESET_PC)
) u_chk (
    .pause_i ({pause_if_i, pause_id_i, pause_dispatch_i, pause_ex_i, pause_mem_i}),
    .*
);

/* test/trap_unit_tb.sv */
module trap_unit_tb
    import trap_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC   = 32'h1c00_0000;
    localparam int          RND_CYCLES = 400;
    localparam int          MAX_CYCLES = 2 * (8 + 40 + RND_CYCLES) + 100;

    logic               clk = 1'b0;
    logic               arst_n_i;
    logic [4:0]         pause;    // if, id, dispatch, ex, mem
    logic [31:0]        mem_pc_i;
    logic [5:0]         mem_is_exception_i;
    logic [5:0][6:0]    mem_exception_cause_i;
    logic [31:0]        mem_exception_addr_i;
    logic               mem_is_ertn_i;
    logic               mem_is_idle_i;
    logic               continue_idle_i;
    logic [7:0]         hw_int_i;
    logic               wb_csr_we_i;
    logic [13:0]        wb_csr_addr_i;
    logic [31:0]        wb_csr_wdata_i;
    logic [13:0]        csr_raddr_i;
    logic [STALL_W-1:0] pause_o;
    logic               flush_o;
    logic [31:0]        new_pc_o;
    logic               is_interrupt_o;
    logic               send_inst1_en_o;
    logic [31:0]        pc_o;
    logic [31:0]        csr_rdata_o;
    int unsigned        cycles = 0;

    excode_e   causes[7] = '{INT, PIF, ADEF, ALE, SYS, BRK, INE};
    csr_addr_e csrs[6]   = '{CRMD, PRMD, ECFG, ESTAT, ERA, EENTRY};

    trap_unit #(.RESET_PC(RESET_PC)) dut_i (
        .pause_if_i       (pause[4]),
        .pause_id_i       (pause[3]),
        .pause_dispatch_i (pause[2]),
        .pause_ex_i       (pause[1]),
        .pause_mem_i      (pause[0]),
        .*
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "run stopped");
    endtask

    always @(negedge clk) begin
        cycles++;
        if (dut_i.u_chk.err_cnt != 0) begin
            abort_run("a checker assertion failed, see the error above");
        end
        else if (cycles > MAX_CYCLES) begin
            abort_run("timeout: the stimulus did not finish within the cycle limit");
        end
    end

    task automatic clear_inputs();
        pause                 = '0;
        mem_pc_i              = BUBBLE_PC;
        mem_is_exception_i    = '0;
        mem_exception_cause_i = '0;
        mem_exception_addr_i  = '0;
        mem_is_ertn_i         = 1'b0;
        mem_is_idle_i         = 1'b0;
        continue_idle_i       = 1'b0;
        wb_csr_we_i           = 1'b0;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic csr_write(input csr_addr_e addr, input logic [31:0] data);
        wb_csr_we_i    = 1'b1;
        wb_csr_addr_i  = addr;
        wb_csr_wdata_i = data;
    endtask

    // every slot gets a random cause
    task automatic mem_trap(input logic [31:0] pc, input logic [5:0] flags);
        mem_pc_i             = pc;
        mem_is_exception_i   = flags;
        mem_exception_addr_i = $urandom;
        for (int k = 0; k < 6; k++) begin
            mem_exception_cause_i[k] = causes[$urandom % 7];
        end
    endtask

    task automatic mem_ertn(input logic [31:0] pc);
        mem_pc_i      = pc;
        mem_is_ertn_i = 1'b1;
    endtask

    initial begin
        void'($urandom(32'h8453_02e4));
        arst_n_i       = 1'b0;
        hw_int_i       = '0;
        csr_raddr_i    = ERA;
        wb_csr_addr_i  = '0;
        wb_csr_wdata_i = '0;
        clear_inputs();
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        repeat (3) next_cycle();                  // pc runs up from RESET_PC
        next_cycle();
        csr_write(EENTRY, 32'h1c00_8000);
        next_cycle();
        csr_write(CRMD, 32'h0000_0004);           // ie
        next_cycle();
        csr_write(ECFG, 32'h0000_1804);
        next_cycle();
        mem_trap(32'h1c00_0100, 6'b010010);
        next_cycle();
        csr_raddr_i = ESTAT;
        mem_trap(BUBBLE_PC, 6'b111111);           // bubble never traps
        next_cycle();
        csr_raddr_i = CRMD;
        mem_ertn(32'h1c00_0200);
        next_cycle();
        mem_trap(32'h1c00_0300, 6'b100001);
        csr_write(EENTRY, 32'h1c00_9000);         // forwarded to new_pc_o
        next_cycle();
        mem_ertn(32'h1c00_0400);
        csr_write(ERA, 32'h1c00_0500);
        hw_int_i = 8'h01;
        next_cycle();
        mem_is_idle_i = 1'b1;                     // interrupt pending so no hold
        hw_int_i      = 8'h00;
        repeat (3) begin
            next_cycle();
            mem_is_idle_i = 1'b1;
        end
        next_cycle();
        mem_is_idle_i   = 1'b1;
        continue_idle_i = 1'b1;
        for (int k = 0; k < 5; k++) begin
            next_cycle();
            pause[k] = 1'b1;
        end
        next_cycle();
        pause = 5'b01101;                         // id is the earliest here
        next_cycle();
        pause = 5'b10000;
        mem_trap(32'h1c00_0600, 6'b000001);       // flush while pc is held

        for (int n = 0; n < RND_CYCLES; n++) begin
            next_cycle();
            csr_raddr_i = csrs[$urandom % 6];
            if ($urandom % 3 == 0) begin
                pause = 5'($urandom);
            end
            if ($urandom % 4 == 0) begin
                mem_trap(($urandom % 8 == 0) ? BUBBLE_PC : $urandom, 6'($urandom));
            end
            else if ($urandom % 6 == 0) begin
                mem_ertn($urandom);
            end
            mem_is_idle_i   = ($urandom % 8 == 0);
            continue_idle_i = ($urandom % 2 == 0);
            if ($urandom % 3 == 0) begin
                csr_write(csrs[$urandom % 6], $urandom);
            end
            if (n % 8 == 0) begin
                hw_int_i = 8'($urandom);
            end
        end

        repeat (2) next_cycle();
        if (dut_i.u_chk.err_cnt == 0) begin
            $display("*** PASSED ***");
            $finish;
        end
        else begin
            abort_run("the checker counted errors by the end of the run");
        end
    end

endmodule

/* verilog/ctrl_csr_if.sv */
interface ctrl_csr_if
    import trap_pkg::*;
();

    // csr state seen by the controller
    logic [31:0] era;
    logic [31:0] eentry;
    logic [11:0] ecfg_lie;
    logic [11:0] estat_is;
    logic        crmd_ie;

    // trap event back to the csr block
    logic        is_exception;
    logic        is_ertn;
    excode_e     exception_cause;
    logic [31:0] exception_pc;
    logic [31:0] exception_addr;

    modport csr (
        output era, eentry, ecfg_lie, estat_is, crmd_ie,
        input  is_exception, is_ertn, exception_cause, exception_pc, exception_addr
    );

    modport ctrl (
        input  era, eentry, ecfg_lie, estat_is, crmd_ie,
        output is_exception, is_ertn, exception_cause, exception_pc, exception_addr
    );

endinterface

/* verilog/fetch_pc.sv */
module fetch_pc
    import trap_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic               clk,
    input  logic               arst_n_i,

    input  logic [STALL_W-1:0] stall_i,
    input  logic               flush_i,
    input  logic [31:0]        new_pc_i,

    output logic [31:0]        pc_o
);

    logic [31:0] pc_q;
    logic [31:0] pc_next;

    // flush beats a stall
    always_comb begin
        if (flush_i) begin
            pc_next = new_pc_i;
        end
        else if (stall_i[STALL_PC]) begin
            pc_next = pc_q;
        end
        else begin
            pc_next = pc_q + 32'd8; // two-instruction fetch group
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end
        else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

/* verilog/trap_csr.sv */
module trap_csr
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n_i,

    input  csr_wr_t     wb_wr_i,
    input  logic [7:0]  hw_int_i,

    input  csr_addr_e   raddr_i,
    output logic [31:0] rdata_o,

    ctrl_csr_if.csr     master
);

    logic [8:0]  crmd_q;        // plv, ie, da, pg, datf, datm
    logic [2:0]  prmd_q;        // pplv, pie
    logic [11:0] ecfg_lie_q;    // lie[12:11] and lie[9:0] packed together
    logic [11:0] estat_is_q;    // same packing as lie
    logic [5:0]  estat_ecode_q;
    logic [31:0] era_q;
    logic [31:0] eentry_q;

    logic [6:0]  cause;
    logic        wr_crmd;
    logic        wr_prmd;
    logic        ie_cur;
    logic        pie_cur;

    assign cause = master.exception_cause;

    assign wr_crmd = wb_wr_i.en && (wb_wr_i.addr == CRMD);
    assign wr_prmd = wb_wr_i.en && (wb_wr_i.addr == PRMD);

    // the write-back instruction is older than the trapping one
    assign ie_cur  = wr_crmd ? wb_wr_i.data[2] : crmd_q[2];
    assign pie_cur = wr_prmd ? wb_wr_i.data[2] : prmd_q[2];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            crmd_q        <= '0;
            prmd_q        <= '0;
            ecfg_lie_q    <= '0;
            estat_is_q    <= '0;
            estat_ecode_q <= '0;
            era_q         <= '0;
            eentry_q      <= '0;
        end
        else begin
            estat_is_q[9:2] <= hw_int_i; // hw lines, resampled every cycle

            if (wb_wr_i.en) begin
                case (wb_wr_i.addr)
                    CRMD:   crmd_q     <= wb_wr_i.data[8:0];
                    PRMD:   prmd_q     <= wb_wr_i.data[2:0];
                    ECFG:   ecfg_lie_q <= {wb_wr_i.data[12:11], wb_wr_i.data[9:0]};
                    ESTAT: begin
                        estat_is_q[1:0]   <= wb_wr_i.data[1:0];
                        estat_is_q[11:10] <= wb_wr_i.data[12:11];
                    end
                    ERA:    era_q      <= wb_wr_i.data;
                    EENTRY: eentry_q   <= wb_wr_i.data;
                    default: ;
                endcase
            end

            // trap fields override a same-cycle write
            if (master.is_exception) begin
                era_q         <= master.exception_pc;
                estat_ecode_q <= cause[5:0];
                prmd_q[2]     <= ie_cur;
                crmd_q[2]     <= 1'b0;
            end
            else if (master.is_ertn) begin
                crmd_q[2] <= pie_cur;
            end
        end
    end

    assign master.era      = era_q;
    assign master.eentry   = eentry_q;
    assign master.ecfg_lie = ecfg_lie_q;
    assign master.estat_is = estat_is_q;
    assign master.crmd_ie  = crmd_q[2];

    always_comb begin
        case (raddr_i)
            CRMD:   rdata_o = {23'b0, crmd_q};
            PRMD:   rdata_o = {29'b0, prmd_q};
            ECFG:   rdata_o = {19'b0, ecfg_lie_q[11:10], 1'b0, ecfg_lie_q[9:0]};
            ESTAT: begin
                // esubcode not kept, reads as zero
                rdata_o = {10'b0, estat_ecode_q, 3'b0,
                           estat_is_q[11:10], 1'b0, estat_is_q[9:0]};
            end
            ERA:    rdata_o = era_q;
            EENTRY: rdata_o = eentry_q;
            default: rdata_o = 32'h0;
        endcase
    end

endmodule

/* verilog/trap_ctrl.sv */
module trap_ctrl
    import trap_pkg::*;
(
    input  pause_req_t         pause_req_i,
    input  mem_trap_t          mem_i,
    input  csr_wr_t            wb_wr_i,
    input  logic               continue_idle_i,

    ctrl_csr_if.ctrl           master,

    output logic [STALL_W-1:0] stall_o,
    output logic               flush_o,
    output logic [31:0]        new_pc_o,
    output logic               is_interrupt_o,
    output logic               send_inst1_en_o
);

    logic [31:0] era_cur;
    logic [31:0] eentry_cur;
    logic [11:0] lie_cur;
    logic [11:0] is_cur;
    logic        ie_cur;

    logic        valid;
    logic        exc_valid;
    logic        ertn_valid;
    logic [11:0] int_vec;
    logic        pause_idle;

    // forward a csr write from write-back in the same cycle
    always_comb begin
        era_cur    = master.era;
        eentry_cur = master.eentry;
        lie_cur    = master.ecfg_lie;
        is_cur     = master.estat_is;
        ie_cur     = master.crmd_ie;
        if (wb_wr_i.en) begin
            case (wb_wr_i.addr)
                ERA:    era_cur    = wb_wr_i.data;
                EENTRY: eentry_cur = wb_wr_i.data;
                ECFG:   lie_cur    = {wb_wr_i.data[12:11], wb_wr_i.data[9:0]};
                ESTAT: begin
                    is_cur[1:0]   = wb_wr_i.data[1:0];   // hw bits stay as sampled
                    is_cur[11:10] = wb_wr_i.data[12:11];
                end
                CRMD:   ie_cur     = wb_wr_i.data[2];
                default: ;
            endcase
        end
    end

    assign valid      = (mem_i.pc != BUBBLE_PC);
    assign exc_valid  = valid && (mem_i.is_exception != '0);
    assign ertn_valid = valid && mem_i.is_ertn && !exc_valid;

    // highest set flag picks the cause
    always_comb begin
        master.exception_cause = EXC_NOP;
        if (exc_valid) begin
            for (int k = 0; k < 6; k++) begin
                if (mem_i.is_exception[k]) begin
                    master.exception_cause = excode_e'(mem_i.exception_cause[k]);
                end
            end
        end
    end

    assign master.is_exception   = exc_valid;
    assign master.is_ertn        = ertn_valid;
    assign master.exception_pc   = mem_i.pc;
    assign master.exception_addr = mem_i.exception_addr;

    assign flush_o  = exc_valid || ertn_valid;
    assign new_pc_o = ertn_valid ? era_cur : eentry_cur;

    assign int_vec        = ie_cur ? (lie_cur & is_cur) : 12'b0;
    assign is_interrupt_o = (int_vec != 12'b0);

    // idle waits here until something wakes it
    assign pause_idle = mem_i.is_idle && !is_interrupt_o && !continue_idle_i;

    always_comb begin
        stall_o = '0;
        if (pause_req_i.pause_if) begin
            stall_o[STALL_PC] = 1'b1;
        end
        else if (pause_req_i.pause_id) begin
            stall_o[STALL_ID:STALL_PC] = '1;
        end
        else if (pause_req_i.pause_dispatch) begin
            stall_o[STALL_DISPATCH:STALL_PC] = '1;
        end
        else if (pause_req_i.pause_ex) begin
            stall_o[STALL_EX:STALL_PC] = '1;
        end
        else if (pause_req_i.pause_mem || pause_idle) begin
            stall_o[STALL_MEM:STALL_PC] = '1;
        end
    end

    assign send_inst1_en_o = !stall_o[STALL_IBUF]; // second slot held with the buffer

endmodule

/* verilog/trap_pkg.sv */
package trap_pkg;

    // LoongArch ecodes, plus two internal markers
    typedef enum logic [6:0] {
        INT        = 7'h00,
        PIF        = 7'h03,
        ADEF       = 7'h08,
        ALE        = 7'h09,
        SYS        = 7'h0b,
        BRK        = 7'h0c,
        INE        = 7'h0d,
        ERTN_DUMMY = 7'h7e,
        EXC_NOP    = 7'h7f
    } excode_e;

    typedef enum logic [13:0] {
        CRMD   = 14'h000,
        PRMD   = 14'h001,
        ECFG   = 14'h004,
        ESTAT  = 14'h005,
        ERA    = 14'h006,
        EENTRY = 14'h00c
    } csr_addr_e;

    localparam int STALL_W = 7;

    // bit k holds stage k and everything in front of it
    localparam int STALL_PC       = 0;
    localparam int STALL_ICACHE   = 1;
    localparam int STALL_IBUF     = 2;
    localparam int STALL_ID       = 3;
    localparam int STALL_DISPATCH = 4;
    localparam int STALL_EX       = 5;
    localparam int STALL_MEM      = 6;

    localparam logic [31:0] BUBBLE_PC = 32'hfc; // pc of an inserted bubble

    typedef struct packed {
        logic pause_if;
        logic pause_id;
        logic pause_dispatch;
        logic pause_ex;
        logic pause_mem;
    } pause_req_t;

    typedef struct packed {
        logic [31:0]     pc;
        logic [5:0]      is_exception;    // one flag per detecting stage
        logic [5:0][6:0] exception_cause;
        logic [31:0]     exception_addr;
        logic            is_ertn;
        logic            is_idle;
    } mem_trap_t;

    typedef struct packed {
        logic        en;
        csr_addr_e   addr;
        logic [31:0] data;
    } csr_wr_t;

endpackage

/* verilog/trap_unit.sv */
module trap_unit
    import trap_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
    input  logic               clk,
    input  logic               arst_n_i,

    input  logic               pause_if_i,
    input  logic               pause_id_i,
    input  logic               pause_dispatch_i,
    input  logic               pause_ex_i,
    input  logic               pause_mem_i,

    input  logic [31:0]        mem_pc_i,
    input  logic [5:0]         mem_is_exception_i,
    input  logic [5:0][6:0]    mem_exception_cause_i,
    input  logic [31:0]        mem_exception_addr_i,
    input  logic               mem_is_ertn_i,
    input  logic               mem_is_idle_i,

    input  logic               continue_idle_i,
    input  logic [7:0]         hw_int_i,

    input  logic               wb_csr_we_i,
    input  logic [13:0]        wb_csr_addr_i,
    input  logic [31:0]        wb_csr_wdata_i,

    input  logic [13:0]        csr_raddr_i,

    output logic [STALL_W-1:0] pause_o,
    output logic               flush_o,
    output logic [31:0]        new_pc_o,
    output logic               is_interrupt_o,
    output logic               send_inst1_en_o,
    output logic [31:0]        pc_o,
    output logic [31:0]        csr_rdata_o
);

    pause_req_t pause_req;
    mem_trap_t  mem_trap;
    csr_wr_t    wb_wr;

    assign pause_req = '{
        pause_if:       pause_if_i,
        pause_id:       pause_id_i,
        pause_dispatch: pause_dispatch_i,
        pause_ex:       pause_ex_i,
        pause_mem:      pause_mem_i
    };

    assign mem_trap = '{
        pc:              mem_pc_i,
        is_exception:    mem_is_exception_i,
        exception_cause: mem_exception_cause_i,
        exception_addr:  mem_exception_addr_i,
        is_ertn:         mem_is_ertn_i,
        is_idle:         mem_is_idle_i
    };

    assign wb_wr = '{en: wb_csr_we_i, addr: csr_addr_e'(wb_csr_addr_i), data: wb_csr_wdata_i};

    ctrl_csr_if ctrl_csr ();

    trap_csr u_csr (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_wr_i  (wb_wr),
        .hw_int_i (hw_int_i),
        .raddr_i  (csr_addr_e'(csr_raddr_i)),
        .rdata_o  (csr_rdata_o),
        .master   (ctrl_csr)
    );

    trap_ctrl u_ctrl (
        .pause_req_i     (pause_req),
        .mem_i           (mem_trap),
        .wb_wr_i         (wb_wr),
        .continue_idle_i (continue_idle_i),
        .master          (ctrl_csr),
        .stall_o         (pause_o),
        .flush_o         (flush_o),
        .new_pc_o        (new_pc_o),
        .is_interrupt_o  (is_interrupt_o),
        .send_inst1_en_o (send_inst1_en_o)
    );

    fetch_pc #(
        .RESET_PC (RESET_PC)
    ) u_fetch_pc (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (pause_o),
        .flush_i  (flush_o),
        .new_pc_i (new_pc_o),
        .pc_o     (pc_o)
    );

endmodule
